/* bus_arbiter.sv */
// Host request decode and window gating
`timescale 1ns/1ps

module bus_arbiter import pet_bus_pkg::*; (
    // Host master side
    input  logic [BUS_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [DATA_WIDTH-1:0]     host_wdata_i,
    output logic [DATA_WIDTH-1:0]     host_rdata_o,
    input  logic                      host_we_i,
    input  logic                      host_cycle_i,
    input  logic                      host_strobe_i,
    output logic                      host_stall_o,
    output logic                      host_ack_o,
    input  logic                      host_window_i,

    // Shared request lines to both slaves
    output logic [BUS_ADDR_WIDTH-1:0] bus_addr_o,
    output logic [DATA_WIDTH-1:0]     bus_wdata_o,
    output logic                      bus_we_o,

    // SRAM bridge
    output logic                      ram_strobe_o,
    input  logic                      ram_stall_i,
    input  logic                      ram_ack_i,
    input  logic [DATA_WIDTH-1:0]     ram_rdata_i,

    // Register file
    output logic                      reg_strobe_o,
    input  logic                      reg_stall_i,
    input  logic                      reg_ack_i,
    input  logic [DATA_WIDTH-1:0]     reg_rdata_i
);
    logic sel_reg;  // Target decode
    logic grant;    // Request may reach a slave this cycle

    assign sel_reg = host_addr_i[REG_SPACE_BIT];

    // Requests only pass while the CPU is off the SRAM
    assign grant = host_cycle_i && host_strobe_i && host_window_i;

    assign ram_strobe_o = grant && !sel_reg;
    assign reg_strobe_o = grant &&  sel_reg;

    assign bus_addr_o  = host_addr_i;
    assign bus_wdata_o = host_wdata_i;
    assign bus_we_o    = host_we_i;

    // Back-pressure outside the host window or while a slave is busy
    assign host_stall_o = !host_window_i || ram_stall_i || reg_stall_i;

    // Only one access is outstanding, so the acks never collide
    assign host_ack_o = ram_ack_i || reg_ack_i;

    // Address is held by the master until ack
    assign host_rdata_o = sel_reg ? reg_rdata_i : ram_rdata_i;

endmodule

/* bus_timing.sv */
// Bus cycle timing generator
`timescale 1ns/1ps

module bus_timing import pet_bus_pkg::*; #(
    parameter int unsigned CYCLE_CLOCKS = 64,
    parameter int unsigned CPU_CLOCKS   = 32
) (
    input  logic sys_clock_i,
    input  logic sys_reset_ni,
    output logic cpu_be_o,
    output logic cpu_clock_o,
    output logic host_window_o
);
    localparam int CNT_WIDTH = $clog2(CYCLE_CLOCKS);

    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] count_next;

    // Wraps after CYCLE_CLOCKS clocks
    assign count_next = (int'(count) == CYCLE_CLOCKS - 1) ? '0 : count + 1'b1;

    // Decodes use the next count so each registered output lines up with count
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            count         <= '0;
            cpu_be_o      <= 1'b1;  // Count 0 belongs to the CPU
            cpu_clock_o   <= 1'b0;
            host_window_o <= 1'b0;
        end else begin
            count       <= count_next;
            cpu_be_o    <= int'(count_next) < CPU_CLOCKS;
            cpu_clock_o <= (int'(count_next) >= CPU_CLOCKS / 2) &&
                           (int'(count_next) < CPU_CLOCKS);
            // Host owns the rest of the cycle minus the guard
            host_window_o <= (int'(count_next) >= CPU_CLOCKS) &&
                             (int'(count_next) < CYCLE_CLOCKS - GUARD_CLOCKS);
        end
    end

endmodule

/* pet_bus.f */
pet_bus_pkg.sv
bus_timing.sv
bus_arbiter.sv
ram_bridge.sv
register_file.sv
spi_bridge.sv
pet_bus_top.sv
tb_clock_gen.sv
tb_pet_bus.sv

/* pet_bus_pkg.sv */
// PET bus controller definitions
package pet_bus_pkg;

    // Data path and address widths
    localparam int DATA_WIDTH     = 8;
    localparam int BUS_ADDR_WIDTH = 20;
    localparam int RAM_ADDR_WIDTH = 17;  // 128 KB SRAM

    // Internal bus address map
    localparam int REG_SPACE_BIT = 19;  // 1 = register file, 0 = SRAM

    // Register indices, taken from the low address byte
    localparam int REG_CPU_CONTROL = 0;

    // Bits of the CPU control register
    localparam int CTRL_READY_BIT = 0;  // Drives cpu_ready_o
    localparam int CTRL_RESET_BIT = 1;  // Drives cpu_reset_o, set out of reset

    // SPI command byte layout
    localparam int CMD_WRITE_BIT = 7;  // 1 = write, 0 = read
    localparam int CMD_REG_BIT   = 6;  // Selects register space
    localparam int CMD_A16_BIT   = 0;  // SRAM address bit 16

    // Clocks at the end of the bus cycle kept free of host accesses,
    // long enough for one SRAM access to finish before the CPU takes over
    localparam int GUARD_CLOCKS = 4;

endpackage

/* pet_bus_top.sv */
// PET bus controller top level
`timescale 1ns/1ps

module pet_bus_top import pet_bus_pkg::*; #(
    parameter int unsigned CYCLE_CLOCKS = 64,
    parameter int unsigned CPU_CLOCKS   = 32
) (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,

    // SPI from the microcontroller
    input  logic                      spi_cs_ni,
    input  logic                      spi_sck_i,
    input  logic                      spi_sd_i,
    output logic                      spi_sd_o,
    output logic                      spi_stall_o,

    // CPU control
    output logic                      cpu_be_o,
    output logic                      cpu_clock_o,
    output logic                      cpu_ready_o,
    output logic                      cpu_reset_o,

    // SRAM
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [DATA_WIDTH-1:0]     ram_data_i,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_data_oe_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o
);
    logic [BUS_ADDR_WIDTH-1:0] host_addr;
    logic [DATA_WIDTH-1:0]     host_wdata;
    logic [DATA_WIDTH-1:0]     host_rdata;
    logic                      host_we;
    logic                      host_cycle;
    logic                      host_strobe;
    logic                      host_stall;
    logic                      host_ack;
    logic                      host_window;

    logic [BUS_ADDR_WIDTH-1:0] bus_addr;
    logic [DATA_WIDTH-1:0]     bus_wdata;
    logic                      bus_we;

    logic                      ram_strobe;
    logic                      ram_stall;
    logic                      ram_ack;
    logic [DATA_WIDTH-1:0]     ram_rdata;
    logic                      reg_strobe;
    logic                      reg_stall;
    logic                      reg_ack;
    logic [DATA_WIDTH-1:0]     reg_rdata;

    spi_bridge u_spi_bridge (
        .sys_clock_i, .sys_reset_ni,
        .spi_cs_ni, .spi_sck_i, .spi_sd_i, .spi_sd_o, .spi_stall_o,
        .host_addr_o(host_addr), .host_wdata_o(host_wdata), .host_rdata_i(host_rdata),
        .host_we_o(host_we), .host_cycle_o(host_cycle), .host_strobe_o(host_strobe),
        .host_stall_i(host_stall), .host_ack_i(host_ack)
    );

    bus_timing #(.CYCLE_CLOCKS(CYCLE_CLOCKS), .CPU_CLOCKS(CPU_CLOCKS)) u_bus_timing (
        .sys_clock_i, .sys_reset_ni,
        .cpu_be_o, .cpu_clock_o, .host_window_o(host_window)
    );

    bus_arbiter u_bus_arbiter (
        .host_addr_i(host_addr), .host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
        .host_we_i(host_we), .host_cycle_i(host_cycle), .host_strobe_i(host_strobe),
        .host_stall_o(host_stall), .host_ack_o(host_ack), .host_window_i(host_window),
        .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata), .bus_we_o(bus_we),
        .ram_strobe_o(ram_strobe), .ram_stall_i(ram_stall),
        .ram_ack_i(ram_ack), .ram_rdata_i(ram_rdata),
        .reg_strobe_o(reg_strobe), .reg_stall_i(reg_stall),
        .reg_ack_i(reg_ack), .reg_rdata_i(reg_rdata)
    );

    ram_bridge u_ram_bridge (
        .sys_clock_i, .sys_reset_ni,
        .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata), .bus_we_i(bus_we),
        .bus_strobe_i(ram_strobe), .bus_stall_o(ram_stall),
        .bus_ack_o(ram_ack), .bus_rdata_o(ram_rdata),
        .ram_addr_o, .ram_data_i, .ram_data_o, .ram_data_oe_o, .ram_oe_o, .ram_we_o
    );

    register_file u_register_file (
        .sys_clock_i, .sys_reset_ni,
        .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata), .bus_we_i(bus_we),
        .bus_strobe_i(reg_strobe), .bus_stall_o(reg_stall),
        .bus_ack_o(reg_ack), .bus_rdata_o(reg_rdata),
        .cpu_ready_o, .cpu_reset_o
    );

endmodule

/* ram_bridge.sv */
// Bus to SRAM pin sequencer
`timescale 1ns/1ps

module ram_bridge import pet_bus_pkg::*; (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,

    // Bus slave
    input  logic [BUS_ADDR_WIDTH-1:0] bus_addr_i,
    input  logic [DATA_WIDTH-1:0]     bus_wdata_i,
    input  logic                      bus_we_i,
    input  logic                      bus_strobe_i,
    output logic                      bus_stall_o,
    output logic                      bus_ack_o,
    output logic [DATA_WIDTH-1:0]     bus_rdata_o,

    // SRAM pins
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [DATA_WIDTH-1:0]     ram_data_i,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_data_oe_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o
);
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,  // Two clocks of OE or WE
        DONE     // Ack cycle
    } state_t;

    state_t state;
    logic   second;  // Second clock of ACCESS

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state         <= IDLE;
            second        <= 1'b0;
            ram_oe_o      <= 1'b0;
            ram_we_o      <= 1'b0;
            ram_data_oe_o <= 1'b0;
        end else begin
            case (state)
                IDLE: if (bus_strobe_i) begin
                    state         <= ACCESS;
                    second        <= 1'b0;
                    ram_oe_o      <= !bus_we_i;
                    ram_we_o      <= bus_we_i;
                    ram_data_oe_o <= bus_we_i;
                end
                ACCESS: if (second) begin
                    state         <= DONE;
                    ram_oe_o      <= 1'b0;
                    ram_we_o      <= 1'b0;
                    ram_data_oe_o <= 1'b0;
                end else begin
                    second <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and write data latched on strobe, read data on the second OE clock
    always_ff @(posedge sys_clock_i) begin
        if (state == IDLE && bus_strobe_i) begin
            ram_addr_o <= bus_addr_i[RAM_ADDR_WIDTH-1:0];
            ram_data_o <= bus_wdata_i;
        end
        if (state == ACCESS && second && ram_oe_o) begin
            bus_rdata_o <= ram_data_i;
        end
    end

    assign bus_stall_o = (state != IDLE);
    assign bus_ack_o   = (state == DONE);  // Three clocks after strobe

endmodule

/* register_file.sv */
// CPU control register file
`timescale 1ns/1ps

module register_file import pet_bus_pkg::*; (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,
    input  logic [BUS_ADDR_WIDTH-1:0] bus_addr_i,
    input  logic [DATA_WIDTH-1:0]     bus_wdata_i,
    input  logic                      bus_we_i,
    input  logic                      bus_strobe_i,
    output logic                      bus_stall_o,
    output logic                      bus_ack_o,
    output logic [DATA_WIDTH-1:0]     bus_rdata_o,
    output logic                      cpu_ready_o,
    output logic                      cpu_reset_o
);
    logic                  sel_ctrl;
    logic [DATA_WIDTH-1:0] ctrl_value;

    // Register index is the low address byte
    assign sel_ctrl = (bus_addr_i[DATA_WIDTH-1:0] == DATA_WIDTH'(REG_CPU_CONTROL));

    always_comb begin
        ctrl_value                 = '0;
        ctrl_value[CTRL_READY_BIT] = cpu_ready_o;
        ctrl_value[CTRL_RESET_BIT] = cpu_reset_o;
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            bus_ack_o   <= 1'b0;
            cpu_ready_o <= 1'b0;
            cpu_reset_o <= 1'b1;  // CPU held in reset until the host releases it
        end else begin
            bus_ack_o <= bus_strobe_i;
            if (bus_strobe_i && bus_we_i && sel_ctrl) begin
                cpu_ready_o <= bus_wdata_i[CTRL_READY_BIT];
                cpu_reset_o <= bus_wdata_i[CTRL_RESET_BIT];
            end
        end
    end

    // Unused indices read as zero
    always_ff @(posedge sys_clock_i) begin
        if (bus_strobe_i) bus_rdata_o <= sel_ctrl ? ctrl_value : '0;
    end

    assign bus_stall_o = 1'b0;  // Single-cycle slave

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the PET bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f pet_bus.f --top-module tb_pet_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_pet_bus)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* spi_bridge.sv */
// SPI command to bus master bridge
`timescale 1ns/1ps

module spi_bridge import pet_bus_pkg::*; (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,

    // SPI target, mode 0, MSB first
    input  logic                      spi_cs_ni,
    input  logic                      spi_sck_i,
    input  logic                      spi_sd_i,
    output logic                      spi_sd_o,
    output logic                      spi_stall_o,

    // Bus master
    output logic [BUS_ADDR_WIDTH-1:0] host_addr_o,
    output logic [DATA_WIDTH-1:0]     host_wdata_o,
    input  logic [DATA_WIDTH-1:0]     host_rdata_i,
    output logic                      host_we_o,
    output logic                      host_cycle_o,
    output logic                      host_strobe_o,
    input  logic                      host_stall_i,
    input  logic                      host_ack_i
);
    logic [1:0] sck_sync;
    logic [1:0] sdi_sync;
    logic [1:0] cs_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic       deselect;

    logic [2:0]            bit_cnt;
    logic [2:0]            byte_idx;  // 0 to 3 in frame, 4 once complete
    logic                  byte_done;
    logic [DATA_WIDTH-1:0] rx_q;
    logic [DATA_WIDTH-1:0] tx_q;
    logic [DATA_WIDTH-1:0] cmd_q;
    logic [DATA_WIDTH-1:0] addr_hi_q;
    logic [DATA_WIDTH-1:0] addr_lo_q;
    logic [DATA_WIDTH-1:0] addr_lo;
    logic                  frame_write;
    logic                  issue;

    // Two-flop synchronizers, plus the previous SCK level for edge detect
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            sck_sync <= '0;
            sdi_sync <= '0;
            cs_sync  <= '1;
            sck_prev <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], spi_sck_i};
            sdi_sync <= {sdi_sync[0], spi_sd_i};
            cs_sync  <= {cs_sync[0], spi_cs_ni};
            sck_prev <= sck_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] && !sck_prev;
    assign deselect = cs_sync[1];  // CS high drops any partial frame

    // Bit and byte counters
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            bit_cnt   <= '0;
            byte_idx  <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (deselect) begin
                bit_cnt  <= '0;
                byte_idx <= '0;
            end else begin
                if (sck_rise) begin
                    bit_cnt   <= bit_cnt + 3'd1;
                    byte_done <= (bit_cnt == 3'd7);  // rx_q full on the next clock
                end
                if (byte_done && byte_idx != 3'd4) byte_idx <= byte_idx + 3'd1;
            end
        end
    end

    assign frame_write = cmd_q[CMD_WRITE_BIT];
    assign addr_lo     = frame_write ? addr_lo_q : rx_q;

    // Reads go out after the address, writes after the data byte
    assign issue = byte_done && !deselect && !host_cycle_o &&
                   ((byte_idx == 3'd2 && !frame_write) || (byte_idx == 3'd3 && frame_write));

    // Shifters, frame fields and the request latched for the bus
    always_ff @(posedge sys_clock_i) begin
        if (!deselect && sck_rise) rx_q <= {rx_q[DATA_WIDTH-2:0], sdi_sync[1]};

        if (host_cycle_o && host_ack_i && !host_we_o) begin
            tx_q <= host_rdata_i;  // Shifted out in the dummy byte
        end else if (!deselect && sck_rise) begin
            tx_q <= {tx_q[DATA_WIDTH-2:0], 1'b0};
        end

        if (byte_done && !deselect) begin
            case (byte_idx)
                3'd0: cmd_q <= rx_q;
                3'd1: addr_hi_q <= rx_q;
                3'd2: addr_lo_q <= rx_q;
                default: ;
            endcase
        end

        if (issue) begin
            host_addr_o                      <= '0;
            host_addr_o[REG_SPACE_BIT]       <= cmd_q[CMD_REG_BIT];
            host_addr_o[RAM_ADDR_WIDTH-1:0]  <= {cmd_q[CMD_A16_BIT], addr_hi_q, addr_lo};
            host_wdata_o                     <= rx_q;
            host_we_o                        <= frame_write;
        end
    end

    // Bus handshake, one access per frame
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            host_cycle_o  <= 1'b0;
            host_strobe_o <= 1'b0;
        end else if (issue) begin
            host_cycle_o  <= 1'b1;
            host_strobe_o <= 1'b1;
        end else begin
            if (host_strobe_o && !host_stall_i) host_strobe_o <= 1'b0;  // Request taken
            if (host_cycle_o && host_ack_i) host_cycle_o <= 1'b0;
        end
    end

    assign spi_stall_o = host_cycle_o;  // MCU waits for this to fall
    assign spi_sd_o    = tx_q[DATA_WIDTH-1];

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,   // 4 ns clock
    parameter int RESET_CYCLES = 10
) (
    output logic clock_o,
    output logic reset_no
);
    initial begin
        clock_o = 1'b0;
        forever #HALF_PERIOD clock_o = ~clock_o;
    end

    // Released on a falling edge, away from the stimulus time
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_no = 1'b1;
    end

endmodule

/* tb_pet_bus.sv */
// PET bus controller testbench
`timescale 1ns/1ps

module tb_pet_bus import pet_bus_pkg::*; ();
    localparam int CYCLE_CLOCKS  = 64;
    localparam int CPU_CLOCKS    = 32;
    localparam int STALL_TIMEOUT = 4 * CYCLE_CLOCKS;
    localparam int RAM_BYTES     = 1 << RAM_ADDR_WIDTH;

    logic                      clk;
    logic                      rst_n;
    logic                      spi_cs_n;
    logic                      spi_sck;
    logic                      spi_sdi;
    logic                      spi_sdo;
    logic                      spi_stall;
    logic                      cpu_be;
    logic                      cpu_clock;
    logic                      cpu_ready;
    logic                      cpu_reset;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic [DATA_WIDTH-1:0]     ram_rd;
    logic [DATA_WIDTH-1:0]     ram_wd;
    logic                      ram_data_oe;
    logic                      ram_oe;
    logic                      ram_we;

    logic [DATA_WIDTH-1:0] sram    [RAM_BYTES];  // Board SRAM
    logic [DATA_WIDTH-1:0] ref_mem [RAM_BYTES];  // Expected contents
    logic [31:0]           rng;
    logic                  model_ready;
    logic                  model_reset;
    int                    errs;  // Errors of the running test
    int                    tests_run;
    int                    tests_failed;
    int                    stall_misses;
    int                    own_errs;
    int                    stall_rises;
    bit                    stall_prev;

    tb_clock_gen u_clock_gen (.clock_o(clk), .reset_no(rst_n));

    pet_bus_top #(.CYCLE_CLOCKS(CYCLE_CLOCKS), .CPU_CLOCKS(CPU_CLOCKS)) u_dut (
        .sys_clock_i(clk), .sys_reset_ni(rst_n),
        .spi_cs_ni(spi_cs_n), .spi_sck_i(spi_sck), .spi_sd_i(spi_sdi),
        .spi_sd_o(spi_sdo), .spi_stall_o(spi_stall),
        .cpu_be_o(cpu_be), .cpu_clock_o(cpu_clock),
        .cpu_ready_o(cpu_ready), .cpu_reset_o(cpu_reset),
        .ram_addr_o(ram_addr), .ram_data_i(ram_rd), .ram_data_o(ram_wd),
        .ram_data_oe_o(ram_data_oe), .ram_oe_o(ram_oe), .ram_we_o(ram_we)
    );

    function automatic logic [DATA_WIDTH-1:0] fill_byte(input logic [16:0] a);
        return a[7:0] ^ {a[15:8]} ^ {a[16], 7'h2d};
    endfunction

    // Galois LFSR stepped once for each bit taken
    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] r;
        r = '0;
        repeat (nbits) begin
            rng = rng[0] ? ((rng >> 1) ^ 32'h8020_0003) : (rng >> 1);
            r   = {r[30:0], rng[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] command_byte(input logic write, input logic reg_space,
                                                input logic a16);
        logic [7:0] c;
        c                = '0;
        c[CMD_WRITE_BIT] = write;
        c[CMD_REG_BIT]   = reg_space;
        c[CMD_A16_BIT]   = a16;
        return c;
    endfunction

    // SRAM model read while OE is high and written on WE
    initial begin : sram_model
        int i;
        for (i = 0; i < RAM_BYTES; i++) sram[17'(i)] = fill_byte(17'(i));
        forever begin
            @(negedge clk);
            if (ram_we && ram_data_oe) sram[ram_addr] = ram_wd;
        end
    end
    assign ram_rd = ram_oe ? sram[ram_addr] : 8'h00;

    // SRAM pins must stay idle while the CPU owns the bus
    always @(negedge clk) begin
        if (cpu_be && (ram_oe || ram_we || ram_data_oe)) begin
            own_errs <= own_errs + 1;
            $display("bus ownership broken: SRAM pins active with cpu_be_o high at %0t", $time);
        end
        if (spi_stall && !stall_prev) stall_rises <= stall_rises + 1;
        stall_prev <= spi_stall;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Mode 0 and MSB first with SCK toggling every 4 clocks
    task automatic spi_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        logic [7:0] sh;
        sh = tx;
        rx = '0;
        repeat (nbits) begin
            spi_sdi = sh[7];
            sh      = {sh[6:0], 1'b0};
            repeat (4) tick();
            rx      = {rx[6:0], spi_sdo};  // Sampled just before SCK rises
            spi_sck = 1'b1;
            repeat (4) tick();
            spi_sck = 1'b0;
        end
    endtask

    task automatic wait_stall_low();
        int n;
        n = 0;
        while (spi_stall && n < STALL_TIMEOUT) begin
            tick();
            n++;
        end
        if (spi_stall) begin
            errs++;
            $display("timeout: spi_stall_o stayed high for %0d clocks", n);
        end
    endtask

    task automatic spi_frame(input logic write, input logic reg_space, input logic [16:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        logic [7:0] rx;
        int         rises;
        rises    = stall_rises;
        spi_cs_n = 1'b0;
        repeat (4) tick();
        spi_byte(command_byte(write, reg_space, addr[16]), 8, rx);
        spi_byte(addr[15:8], 8, rx);
        spi_byte(addr[7:0], 8, rx);
        if (!write) wait_stall_low();  // Read data arrives before the dummy byte
        spi_byte(write ? wdata : 8'h00, 8, rdata);
        if (write) wait_stall_low();
        repeat (4) tick();
        spi_cs_n = 1'b1;
        repeat (8) tick();
        if (stall_rises == rises) begin
            stall_misses++;
            $display("frame to %05h ended without spi_stall_o rising", addr);
        end
    endtask

    // Write frame cut off by CS partway through the data byte
    task automatic spi_abort(input logic [7:0] cmd, input logic [15:0] addr, input int nbits);
        logic [7:0] rx;
        spi_cs_n = 1'b0;
        repeat (4) tick();
        spi_byte(cmd, 8, rx);
        spi_byte(addr[15:8], 8, rx);
        spi_byte(addr[7:0], 8, rx);
        spi_byte(8'(next_random(8)), nbits, rx);
        repeat (4) tick();
        spi_cs_n = 1'b1;
        repeat (8) tick();
    endtask

    task automatic count_to_be_rise(output int period, output int high, output int clock_errs);
        logic prev;
        period     = 0;
        high       = 0;
        clock_errs = 0;
        do begin
            if (cpu_be) high++;
            // CPU clock high in the second half of the CPU window
            if (cpu_clock !== (period >= CPU_CLOCKS / 2 && period < CPU_CLOCKS)) clock_errs++;
            prev = cpu_be;
            tick();
            period++;
        end while (!(cpu_be && !prev) && period < 3 * CYCLE_CLOCKS);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
        errs = 0;
    endtask

    initial begin : main_seq
        logic [16:0] addrs [$];
        logic [16:0] a;
        logic [7:0]  data;
        logic [7:0]  rd;
        logic [7:0]  exp_byte;
        int          i;
        int          n;
        int          period;
        int          high;
        int          clock_errs;
        int          rises;
        int          mism;

        spi_cs_n    = 1'b1;
        spi_sck     = 1'b0;
        spi_sdi     = 1'b0;
        rng         = 32'h85b7;
        model_ready = 1'b0;
        model_reset = 1'b1;  // CPU starts held in reset
        errs        = 0;
        for (i = 0; i < RAM_BYTES; i++) ref_mem[17'(i)] = fill_byte(17'(i));

        n = 0;
        while (rst_n !== 1'b1 && n < 40) begin
            tick();
            n++;
        end
        if (rst_n !== 1'b1) begin
            errs++;
            $display("reset was never released");
        end
        tick();
        if ({spi_stall, ram_oe, ram_we, ram_data_oe, cpu_ready, u_dut.host_cycle} !== 6'b0) begin
            errs++;
            $display("FAIL reset_state low outputs: expected 000000, actual %b",
                     {spi_stall, ram_oe, ram_we, ram_data_oe, cpu_ready, u_dut.host_cycle});
        end
        if (cpu_reset !== 1'b1) begin
            errs++;
            $display("FAIL reset_state cpu_reset_o: expected 1, actual %b", cpu_reset);
        end
        report_test("reset_state");

        count_to_be_rise(period, high, clock_errs);  // Align to a CPU window start
        count_to_be_rise(period, high, clock_errs);
        if (period != CYCLE_CLOCKS) begin
            errs++;
            $display("FAIL window_cadence period: expected %0d, actual %0d", CYCLE_CLOCKS, period);
        end
        if (high != CPU_CLOCKS) begin
            errs++;
            $display("FAIL window_cadence cpu_be_o high: expected %0d, actual %0d",
                     CPU_CLOCKS, high);
        end
        if (clock_errs != 0) begin
            errs++;
            $display("FAIL window_cadence cpu_clock_o wrong clocks: expected 0, actual %0d",
                     clock_errs);
        end
        report_test("window_cadence");

        repeat (40) begin
            a    = 17'(next_random(17));
            data = 8'(next_random(8));
            spi_frame(1'b1, 1'b0, a, data, rd);
            ref_mem[a] = data;
            addrs.push_back(a);
        end
        foreach (addrs[k]) begin
            spi_frame(1'b0, 1'b0, addrs[k], 8'h00, rd);
            if (rd !== ref_mem[addrs[k]]) begin
                errs++;
                $display("FAIL ram_readback %05h: expected %02h, actual %02h",
                         addrs[k], ref_mem[addrs[k]], rd);
            end
        end
        report_test("ram_readback");

        repeat (8) begin
            data = 8'(next_random(8));
            spi_frame(1'b1, 1'b1, 17'(REG_CPU_CONTROL), data, rd);
            model_ready = data[CTRL_READY_BIT];
            model_reset = data[CTRL_RESET_BIT];
            if ({cpu_reset, cpu_ready} !== {model_reset, model_ready}) begin
                errs++;
                $display("FAIL register_control pins: expected %b, actual %b",
                         {model_reset, model_ready}, {cpu_reset, cpu_ready});
            end
            exp_byte                 = '0;
            exp_byte[CTRL_READY_BIT] = model_ready;
            exp_byte[CTRL_RESET_BIT] = model_reset;
            spi_frame(1'b0, 1'b1, 17'(REG_CPU_CONTROL), 8'h00, rd);
            if (rd !== exp_byte) begin
                errs++;
                $display("FAIL register_control readback: expected %02h, actual %02h",
                         exp_byte, rd);
            end
        end
        report_test("register_control");

        rises = stall_rises;
        a     = 17'(next_random(17));
        spi_abort(command_byte(1'b1, 1'b0, a[16]), a[15:0], 5);
        spi_abort(command_byte(1'b1, 1'b1, 1'b0), 16'(REG_CPU_CONTROL), 7);
        if (stall_rises != rises) begin
            errs++;
            $display("aborted frames raised spi_stall_o %0d times", stall_rises - rises);
        end
        if ({cpu_reset, cpu_ready} !== {model_reset, model_ready}) begin
            errs++;
            $display("FAIL backpressure_abort register pins: expected %b, actual %b",
                     {model_reset, model_ready}, {cpu_reset, cpu_ready});
        end
        spi_frame(1'b0, 1'b0, a, 8'h00, rd);
        if (rd !== ref_mem[a]) begin
            errs++;
            $display("FAIL backpressure_abort readback %05h: expected %02h, actual %02h",
                     a, ref_mem[a], rd);
        end
        mism = 0;
        for (i = 0; i < RAM_BYTES; i++) begin
            if (sram[17'(i)] !== ref_mem[17'(i)]) mism++;
        end
        if (mism != 0) begin
            errs++;
            $display("FAIL backpressure_abort sram mismatches: expected 0, actual %0d", mism);
        end
        errs = errs + stall_misses;  // Frames whose stall never rose
        report_test("backpressure_abort");

        errs = own_errs;
        report_test("bus_ownership");

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
